/* design/npu_cfg.svh */
`ifndef NPU_CFG_SVH
`define NPU_CFG_SVH

// ---------------------------------------------------------------------------
// datapath geometry
// ---------------------------------------------------------------------------

// eight int8 lanes packed into one 64-bit word
`define NPU_LANES       8
`define NPU_LANE_W      8
`define NPU_WORD_W      64

// ---------------------------------------------------------------------------
// bank size and statistics
// ---------------------------------------------------------------------------

`define NPU_BANK_DEPTH  64
`define NPU_ADDR_W      6

// cycle and access counters
`define NPU_CNT_W       32

`endif

/* design/npu_data_pkg.sv */
`default_nettype none

`include "npu_cfg.svh"

package npu_data_pkg;

    // one packed stream / bank word
    typedef logic [`NPU_WORD_W-1:0] word_t;

    // one signed element of a word
    typedef logic signed [`NPU_LANE_W-1:0] lane_t;

    // word address inside a bank
    typedef logic [`NPU_ADDR_W-1:0] addr_t;

    // word count, one bit wider so a full bank fits
    typedef logic [`NPU_ADDR_W:0] count_t;

    // statistics counters
    typedef logic [`NPU_CNT_W-1:0] ctr_t;

endpackage

`default_nettype wire

/* design/npu_ctrl_pkg.sv */
`default_nettype none

package npu_ctrl_pkg;

    // layer sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_done,
        st_drain
    } layer_state_e;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_mul
    } ew_op_e;

    // input tuser picks the destination bank
    typedef enum logic {
        bank_a,
        bank_b
    } bank_sel_e;

endpackage

`default_nettype wire

/* design/sram_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sram_port_if
    import npu_data_pkg::*;
();

    logic  en;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    // second read word, only the A/B compute port uses it
    word_t rdata_b;

    modport requester (output en, we, addr, wdata, input rdata, rdata_b);

    modport memory (input en, we, addr, wdata, output rdata, rdata_b);

endinterface

`default_nettype wire

/* design/stream_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_loader
    import npu_data_pkg::*;
    import npu_ctrl_pkg::*;
(
    input  logic              s00_axis_aclk,
    input  logic              arst_n_i,
    input  word_t             s_axis_tdata_i,
    input  bank_sel_e         s_axis_tuser_i,
    input  logic              s_axis_tvalid_i,
    input  logic              s_axis_tlast_i,
    input  logic              accept_i,
    output logic              s_axis_tready_o,
    sram_port_if.requester    load_port,
    output bank_sel_e         bank_o
);

    logic      beat;
    addr_t     wr_addr_q;
    addr_t     cur_addr;
    bank_sel_e bank_q;

    // only take data while the layer FSM is idle
    assign s_axis_tready_o = accept_i;
    assign beat            = s_axis_tvalid_i && accept_i;

    // switching banks starts the new bank from word 0
    assign cur_addr = (s_axis_tuser_i != bank_q) ? '0 : wr_addr_q;

    assign load_port.en    = beat;
    assign load_port.we    = 1'b1;
    assign load_port.addr  = cur_addr;
    assign load_port.wdata = s_axis_tdata_i;
    assign bank_o          = s_axis_tuser_i;

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_addr_q <= '0;
            bank_q    <= bank_a;
        end else if (beat) begin
            bank_q    <= s_axis_tuser_i;
            // tlast closes the block
            wr_addr_q <= s_axis_tlast_i ? '0 : cur_addr + addr_t'(1);
        end
    end

endmodule

`default_nettype wire

/* design/sram_banks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "npu_cfg.svh"

module sram_banks
    import npu_data_pkg::*;
(
    input  logic          s00_axis_aclk,
    input  logic          arst_n_i,
    sram_port_if.memory   load_port,
    sram_port_if.memory   a_port,
    sram_port_if.memory   res_port,
    sram_port_if.memory   out_port,
    input  logic          load_bank_i,
    output ctr_t          access_count_o
);

    word_t      mem_a [`NPU_BANK_DEPTH];
    word_t      mem_b [`NPU_BANK_DEPTH];
    word_t      mem_r [`NPU_BANK_DEPTH];
    logic [2:0] access_inc;

    // ------------------------------------------------------------------------
    // storage, one-cycle read latency
    // ------------------------------------------------------------------------

    always_ff @(posedge s00_axis_aclk) begin
        if (load_port.en && load_port.we) begin
            if (load_bank_i) begin
                mem_b[load_port.addr] <= load_port.wdata;
            end else begin
                mem_a[load_port.addr] <= load_port.wdata;
            end
        end
        // A and B share the compute address
        if (a_port.en) begin
            a_port.rdata   <= mem_a[a_port.addr];
            a_port.rdata_b <= mem_b[a_port.addr];
        end
        if (res_port.en && res_port.we) begin
            mem_r[res_port.addr] <= res_port.wdata;
        end
        if (out_port.en) begin
            out_port.rdata <= mem_r[out_port.addr];
        end
    end

    // write-only ports return nothing
    assign load_port.rdata   = '0;
    assign load_port.rdata_b = '0;
    assign res_port.rdata    = '0;
    assign res_port.rdata_b  = '0;
    assign out_port.rdata_b  = '0;

    // ------------------------------------------------------------------------
    // access statistics
    // ------------------------------------------------------------------------

    // a compute read touches two banks
    assign access_inc = {2'b00, load_port.en} + {1'b0, a_port.en, 1'b0}
                      + {2'b00, res_port.en} + {2'b00, out_port.en};

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            access_count_o <= '0;
        end else begin
            access_count_o <= access_count_o + ctr_t'(access_inc);
        end
    end

endmodule

`default_nettype wire

/* design/layer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "npu_cfg.svh"

module layer_ctrl
    import npu_ctrl_pkg::*;
(
    input  logic                  s00_axis_aclk,
    input  logic                  arst_n_i,
    input  logic                  start_i,
    input  ew_op_e                op_i,
    input  logic [`NPU_ADDR_W:0]  word_count_i,
    input  logic                  compute_done_i,
    input  logic                  drain_done_i,
    output layer_state_e          state_o,
    output ew_op_e                op_o,
    output logic [`NPU_ADDR_W:0]  count_o,
    output logic                  compute_start_o,
    output logic                  drain_start_o,
    output logic                  layer_done_o,
    output logic [`NPU_CNT_W-1:0] cycle_count_o
);

    layer_state_e state_q;
    layer_state_e state_d;
    logic         start_ok;

    // start is ignored outside idle
    assign start_ok = (state_q == st_idle) && start_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start_i) begin
                    state_d = st_compute;
                end
            end
            st_compute: begin
                if (compute_done_i) begin
                    state_d = st_done;
                end
            end
            st_done: begin
                state_d = st_drain;
            end
            st_drain: begin
                if (drain_done_i) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q         <= st_idle;
            op_o            <= op_add;
            count_o         <= '0;
            compute_start_o <= 1'b0;
            drain_start_o   <= 1'b0;
            cycle_count_o   <= '0;
        end else begin
            state_q         <= state_d;
            // pulses line up with the first cycle of the new state
            compute_start_o <= start_ok;
            drain_start_o   <= (state_q == st_done);
            if (start_ok) begin
                op_o          <= op_i;
                count_o       <= word_count_i;
                cycle_count_o <= '0;
            end else if (state_q == st_compute) begin
                cycle_count_o <= cycle_count_o + 1'b1;
            end
        end
    end

    assign state_o      = state_q;
    assign layer_done_o = (state_q == st_done);

endmodule

`default_nettype wire

/* design/elementwise_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "npu_cfg.svh"

module elementwise_unit
    import npu_data_pkg::*;
    import npu_ctrl_pkg::*;
(
    input  logic              s00_axis_aclk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  ew_op_e            op_i,
    input  count_t            count_i,
    sram_port_if.requester    a_port,
    sram_port_if.requester    res_port,
    output logic              done_o
);

    // products of two int8 values fit in 16 bits
    localparam int FULL_W = 2 * `NPU_LANE_W;

    logic  busy_q;
    logic  rd_en;
    addr_t rd_addr_q;
    addr_t cur_addr;
    logic  v1_q;
    logic  v2_q;
    addr_t a1_q;
    addr_t a2_q;
    word_t res_d;
    word_t res_q;

    function automatic lane_t sat_lane(input logic signed [FULL_W-1:0] v);
        if (v > 127) begin
            return 8'sd127;
        end else if (v < -128) begin
            return -8'sd128;
        end
        return v[`NPU_LANE_W-1:0];
    endfunction

    // ------------------------------------------------------------------------
    // read sequencer, first read in the start cycle
    // ------------------------------------------------------------------------

    assign rd_en    = start_i || busy_q;
    assign cur_addr = start_i ? '0 : rd_addr_q;

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            rd_addr_q <= '0;
        end else if (rd_en) begin
            rd_addr_q <= cur_addr + addr_t'(1);
            busy_q    <= ({1'b0, cur_addr} + count_t'(1)) < count_i;
        end
    end

    assign a_port.en    = rd_en;
    assign a_port.we    = 1'b0;
    assign a_port.addr  = cur_addr;
    assign a_port.wdata = '0;

    // ------------------------------------------------------------------------
    // lane math on the read data
    // ------------------------------------------------------------------------

    always_comb begin
        lane_t                    a_l;
        lane_t                    b_l;
        logic signed [FULL_W-1:0] full;
        res_d = '0;
        for (int i = 0; i < `NPU_LANES; i++) begin
            a_l = a_port.rdata[i*`NPU_LANE_W +: `NPU_LANE_W];
            b_l = a_port.rdata_b[i*`NPU_LANE_W +: `NPU_LANE_W];
            case (op_i)
                op_add:  full = FULL_W'(a_l) + FULL_W'(b_l);
                op_sub:  full = FULL_W'(a_l) - FULL_W'(b_l);
                default: full = FULL_W'(a_l) * FULL_W'(b_l);
            endcase
            res_d[i*`NPU_LANE_W +: `NPU_LANE_W] = sat_lane(full);
        end
    end

    // valid tokens for the two words in flight
    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= rd_en;
            v2_q <= v1_q;
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        a1_q  <= cur_addr;
        a2_q  <= a1_q;
        res_q <= res_d;
    end

    assign res_port.en    = v2_q;
    assign res_port.we    = 1'b1;
    assign res_port.addr  = a2_q;
    assign res_port.wdata = res_q;

    // reads are back to back, so the pipe drains on the last write
    assign done_o = v2_q && !v1_q;

endmodule

`default_nettype wire

/* design/stream_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_writer
    import npu_data_pkg::*;
(
    input  logic              s00_axis_aclk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  count_t            count_i,
    sram_port_if.requester    out_port,
    output word_t             m_axis_tdata_o,
    output logic              m_axis_tvalid_o,
    output logic              m_axis_tlast_o,
    input  logic              m_axis_tready_i,
    output logic              done_o
);

    addr_t rd_addr_q;
    addr_t cur_addr;
    logic  issue_q;
    logic  tvalid_q;
    logic  tlast_q;
    logic  handshake;

    // next read goes out only after the previous word is taken
    assign out_port.en    = start_i || issue_q;
    assign out_port.we    = 1'b0;
    assign out_port.addr  = cur_addr;
    assign out_port.wdata = '0;

    assign cur_addr  = start_i ? '0 : rd_addr_q;
    assign handshake = tvalid_q && m_axis_tready_i;

    always_ff @(posedge s00_axis_aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_addr_q <= '0;
            issue_q   <= 1'b0;
            tvalid_q  <= 1'b0;
            tlast_q   <= 1'b0;
        end else if (out_port.en) begin
            rd_addr_q <= cur_addr + addr_t'(1);
            issue_q   <= 1'b0;
            tvalid_q  <= 1'b1;
            tlast_q   <= ({1'b0, cur_addr} + count_t'(1)) == count_i;
        end else if (handshake) begin
            tvalid_q  <= 1'b0;
            tlast_q   <= 1'b0;
            issue_q   <= !tlast_q;
        end
    end

    // read data holds until the next read, which waits for the handshake
    assign m_axis_tdata_o  = out_port.rdata;
    assign m_axis_tvalid_o = tvalid_q;
    assign m_axis_tlast_o  = tlast_q;

    assign done_o = handshake && tlast_q;

endmodule

`default_nettype wire

/* design/npu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_top
    import npu_data_pkg::*;
    import npu_ctrl_pkg::*;
(
    input  logic      s00_axis_aclk,
    input  logic      arst_n_i,
    // input stream into bank A or B
    input  word_t     s_axis_tdata_i,
    input  bank_sel_e s_axis_tuser_i,
    input  logic      s_axis_tvalid_i,
    input  logic      s_axis_tlast_i,
    output logic      s_axis_tready_o,
    // layer command
    input  logic      start_i,
    input  ew_op_e    op_i,
    input  count_t    word_count_i,
    // result stream
    output word_t     m_axis_tdata_o,
    output logic      m_axis_tvalid_o,
    output logic      m_axis_tlast_o,
    input  logic      m_axis_tready_i,
    // status
    output logic      layer_done_o,
    output ctr_t      cycle_count_o,
    output ctr_t      sram_access_count_o
);

    layer_state_e layer_state;
    ew_op_e       layer_op;
    count_t       layer_count;
    logic         compute_start;
    logic         compute_done;
    logic         drain_start;
    logic         drain_done;
    bank_sel_e    load_bank;

    sram_port_if load_port ();
    sram_port_if a_port ();
    sram_port_if res_port ();
    sram_port_if out_port ();

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    layer_ctrl i_layer_ctrl (
        .s00_axis_aclk   (s00_axis_aclk),
        .arst_n_i        (arst_n_i),
        .start_i         (start_i),
        .op_i            (op_i),
        .word_count_i    (word_count_i),
        .compute_done_i  (compute_done),
        .drain_done_i    (drain_done),
        .state_o         (layer_state),
        .op_o            (layer_op),
        .count_o         (layer_count),
        .compute_start_o (compute_start),
        .drain_start_o   (drain_start),
        .layer_done_o    (layer_done_o),
        .cycle_count_o   (cycle_count_o)
    );

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    stream_loader i_stream_loader (
        .s00_axis_aclk   (s00_axis_aclk),
        .arst_n_i        (arst_n_i),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tuser_i  (s_axis_tuser_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .accept_i        (layer_state == st_idle),
        .s_axis_tready_o (s_axis_tready_o),
        .load_port       (load_port),
        .bank_o          (load_bank)
    );

    sram_banks i_sram_banks (
        .s00_axis_aclk  (s00_axis_aclk),
        .arst_n_i       (arst_n_i),
        .load_port      (load_port),
        .a_port         (a_port),
        .res_port       (res_port),
        .out_port       (out_port),
        .load_bank_i    (load_bank),
        .access_count_o (sram_access_count_o)
    );

    elementwise_unit i_elementwise_unit (
        .s00_axis_aclk (s00_axis_aclk),
        .arst_n_i      (arst_n_i),
        .start_i       (compute_start),
        .op_i          (layer_op),
        .count_i       (layer_count),
        .a_port        (a_port),
        .res_port      (res_port),
        .done_o        (compute_done)
    );

    stream_writer i_stream_writer (
        .s00_axis_aclk   (s00_axis_aclk),
        .arst_n_i        (arst_n_i),
        .start_i         (drain_start),
        .count_i         (layer_count),
        .out_port        (out_port),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tready_i (m_axis_tready_i),
        .done_o          (drain_done)
    );

endmodule

`default_nettype wire

/* bench/npu_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "npu_cfg.svh"

module npu_top_tb
    import npu_data_pkg::*;
    import npu_ctrl_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    localparam int LAYERS     = 12;
    localparam int TIMEOUT_NS = LAYERS * (3 * `NPU_BANK_DEPTH + 200) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h261d_7f55;

    logic      s00_axis_aclk;
    logic      arst_n_i;
    word_t     s_axis_tdata_i;
    bank_sel_e s_axis_tuser_i;
    logic      s_axis_tvalid_i;
    logic      s_axis_tlast_i;
    logic      s_axis_tready_o;
    logic      start_i;
    ew_op_e    op_i;
    count_t    word_count_i;
    word_t     m_axis_tdata_o;
    logic      m_axis_tvalid_o;
    logic      m_axis_tlast_o;
    logic      m_axis_tready_i;
    logic      layer_done_o;
    ctr_t      cycle_count_o;
    ctr_t      sram_access_count_o;

    // model state
    word_t       mem_a [`NPU_BANK_DEPTH];
    word_t       mem_b [`NPU_BANK_DEPTH];
    word_t       exp_words [`NPU_BANK_DEPTH];
    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic        backpressure;
    int          cur_n;
    int          beats_seen;
    int          done_pulses;
    int          checks;
    int          errors;
    longint      expected_access;

    // stall tracking in the output monitor
    logic  stall_q;
    word_t stall_data;
    logic  stall_last;

    npu_top i_npu_top (
        .s00_axis_aclk       (s00_axis_aclk),
        .arst_n_i            (arst_n_i),
        .s_axis_tdata_i      (s_axis_tdata_i),
        .s_axis_tuser_i      (s_axis_tuser_i),
        .s_axis_tvalid_i     (s_axis_tvalid_i),
        .s_axis_tlast_i      (s_axis_tlast_i),
        .s_axis_tready_o     (s_axis_tready_o),
        .start_i             (start_i),
        .op_i                (op_i),
        .word_count_i        (word_count_i),
        .m_axis_tdata_o      (m_axis_tdata_o),
        .m_axis_tvalid_o     (m_axis_tvalid_o),
        .m_axis_tlast_o      (m_axis_tlast_o),
        .m_axis_tready_i     (m_axis_tready_i),
        .layer_done_o        (layer_done_o),
        .cycle_count_o       (cycle_count_o),
        .sram_access_count_o (sram_access_count_o)
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw_random();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    // some lanes pinned to the int8 extremes
    function automatic logic [7:0] random_lane();
        logic [31:0] r;
        r = draw_random();
        case (r[27:24])
            4'd0:    return 8'h7f;
            4'd1:    return 8'h80;
            4'd2:    return 8'h81;
            default: return r[23:16];
        endcase
    endfunction

    function automatic word_t random_word();
        word_t w;
        for (int i = 0; i < `NPU_LANES; i++) begin
            w[i*`NPU_LANE_W +: `NPU_LANE_W] = random_lane();
        end
        return w;
    endfunction

    // full precision result clamped to -128..127
    function automatic logic [7:0] expected_lane(input logic [7:0] a, input logic [7:0] b,
                                                 input ew_op_e op);
        int av;
        int bv;
        int r;
        av = int'($signed(a));
        bv = int'($signed(b));
        case (op)
            op_add:  r = av + bv;
            op_sub:  r = av - bv;
            default: r = av * bv;
        endcase
        if (r > 127) begin
            r = 127;
        end else if (r < -128) begin
            r = -128;
        end
        return r[7:0];
    endfunction

    function automatic word_t expected_word(input word_t a, input word_t b, input ew_op_e op);
        word_t w;
        w = '0;
        for (int i = 0; i < `NPU_LANES; i++) begin
            w[i*`NPU_LANE_W +: `NPU_LANE_W] = expected_lane(a[i*`NPU_LANE_W +: `NPU_LANE_W],
                                                            b[i*`NPU_LANE_W +: `NPU_LANE_W], op);
        end
        return w;
    endfunction

    // called on a rising edge and returns on the edge that takes the beat
    task automatic send_beat(input word_t data, input bank_sel_e bank, input logic last);
        logic taken;
        s_axis_tdata_i  <= data;
        s_axis_tuser_i  <= bank;
        s_axis_tvalid_i <= 1'b1;
        s_axis_tlast_i  <= last;
        taken = 1'b0;
        while (!taken) begin
            @(negedge s00_axis_aclk);
            taken = s_axis_tready_o;
            @(posedge s00_axis_aclk);
        end
    endtask

    task automatic load_bank(input bank_sel_e bank, input int n, input logic with_last);
        for (int i = 0; i < n; i++) begin
            send_beat((bank == bank_a) ? mem_a[i] : mem_b[i], bank,
                      with_last && (i == n - 1));
        end
    endtask

    // ------------------------------------------------------------------------
    // clock, ready pattern, watchdog
    // ------------------------------------------------------------------------

    initial begin
        s00_axis_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) s00_axis_aclk = ~s00_axis_aclk;
    end

    // ready about three beats in four when back-pressure is on
    always @(posedge s00_axis_aclk) begin
        ready_state = lcg_next(ready_state);
        m_axis_tready_i <= backpressure ? (ready_state[31:30] != 2'b00) : 1'b1;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------------------------------------------------
    // output monitor sampled on the falling edge
    // ------------------------------------------------------------------------

    always @(negedge s00_axis_aclk) begin
        if (arst_n_i) begin
            if (layer_done_o) begin
                done_pulses++;
            end
            if (stall_q) begin
                if (!m_axis_tvalid_o) begin
                    report_error("tvalid dropped while the output was stalled");
                end else begin
                    check_value(m_axis_tdata_o, stall_data, "tdata held during stall");
                    check_value(m_axis_tlast_o, stall_last, "tlast held during stall");
                end
            end
            stall_q    = m_axis_tvalid_o && !m_axis_tready_i;
            stall_data = m_axis_tdata_o;
            stall_last = m_axis_tlast_o;
            if (m_axis_tvalid_o && m_axis_tready_i) begin
                if (beats_seen >= cur_n) begin
                    report_error("output beat beyond the word count of the layer");
                end else begin
                    if (beats_seen == 0) begin
                        check_value(done_pulses, 1, "layer_done before first beat");
                    end
                    check_value(m_axis_tdata_o, exp_words[beats_seen],
                                $sformatf("output word %0d", beats_seen));
                    check_value(m_axis_tlast_o, beats_seen == cur_n - 1,
                                $sformatf("tlast on word %0d", beats_seen));
                end
                beats_seen++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        int        n;
        ew_op_e    op;
        bank_sel_e first;
        arst_n_i        = 1'b0;
        s_axis_tdata_i  = '0;
        s_axis_tuser_i  = bank_a;
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        start_i         = 1'b0;
        op_i            = op_add;
        word_count_i    = '0;
        m_axis_tready_i = 1'b1;
        stim_state      = SEED;
        ready_state     = ~SEED;
        backpressure    = 1'b0;
        cur_n           = 0;
        beats_seen      = 0;
        done_pulses     = 0;
        checks          = 0;
        errors          = 0;
        expected_access = 0;
        stall_q         = 1'b0;
        stall_data      = '0;
        stall_last      = 1'b0;

        repeat (8) @(posedge s00_axis_aclk);
        arst_n_i <= 1'b1;

        // idle outputs straight after reset
        @(negedge s00_axis_aclk);
        check_value(s_axis_tready_o, 1, "tready after reset");
        check_value(m_axis_tvalid_o, 0, "tvalid after reset");
        check_value(m_axis_tlast_o, 0, "tlast after reset");
        check_value(layer_done_o, 0, "layer_done after reset");
        check_value(cycle_count_o, 0, "cycle count after reset");
        check_value(sram_access_count_o, 0, "access count after reset");
        @(posedge s00_axis_aclk);

        for (int layer = 0; layer < LAYERS; layer++) begin
            // first layers pin a full bank, a single word and each op
            if (layer == 0) begin
                n = `NPU_BANK_DEPTH;
            end else if (layer == 1) begin
                n = 1;
            end else begin
                n = int'(draw_random() >> 26) + 1;
            end
            if (layer < 3) begin
                op = ew_op_e'(layer);
            end else begin
                op = ew_op_e'((draw_random() >> 16) % 3);
            end
            for (int i = 0; i < n; i++) begin
                mem_a[i]     = random_word();
                mem_b[i]     = random_word();
                exp_words[i] = expected_word(mem_a[i], mem_b[i], op);
            end
            backpressure <= (layer % 2 == 1);

            // the first block repeats the last bank of the previous layer and ends
            // without tlast so the second block only restarts on the bank switch
            first = (layer % 2 == 0) ? bank_a : bank_b;
            load_bank(first, n, 1'b0);
            load_bank((first == bank_a) ? bank_b : bank_a, n, 1'b1);
            expected_access += 6 * n;

            cur_n       = n;
            beats_seen  = 0;
            done_pulses = 0;
            s_axis_tvalid_i <= 1'b0;
            s_axis_tlast_i  <= 1'b0;
            start_i         <= 1'b1;
            op_i            <= op;
            word_count_i    <= count_t'(n);
            @(posedge s00_axis_aclk);
            start_i <= 1'b0;

            while (beats_seen < n) begin
                @(posedge s00_axis_aclk);
            end

            // layer finished on the last handshake
            @(negedge s00_axis_aclk);
            if (!s_axis_tready_o) begin
                report_error($sformatf("FSM not back in idle after layer %0d", layer));
            end
            check_value(m_axis_tvalid_o, 0, $sformatf("tvalid after layer %0d", layer));
            check_value(done_pulses, 1, $sformatf("layer_done pulses in layer %0d", layer));
            check_value(cycle_count_o, n + 2, $sformatf("cycle count of layer %0d", layer));
            check_value(sram_access_count_o, expected_access,
                        $sformatf("access count after layer %0d", layer));
            @(posedge s00_axis_aclk);
        end

        repeat (4) @(posedge s00_axis_aclk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* npu_top.f */
+incdir+design
design/npu_data_pkg.sv
design/npu_ctrl_pkg.sv
design/sram_port_if.sv
design/stream_loader.sv
design/sram_banks.sv
design/layer_ctrl.sv
design/elementwise_unit.sv
design/stream_writer.sv
design/npu_top.sv
bench/npu_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module npu_top_tb -f npu_top.f -o npu_sim

result=$(./obj_dir/npu_sim)
echo "$result"
if echo "$result" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
